//--- Bender.yml
package:
  name: uart_port

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uartPkg.sv
      - baudGen.sv
      - uartRec.sv
      - uartTrans.sv
      - uartFifo.sv
      - uartPort.sv
      - uartTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - uartTb.sv

//--- baudGen.sv
//////////////////////////////
// 16x oversampling tick for receiver and transmitter
// sTick is high one clock in every uartTickDiv clocks
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module baudGen
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	localparam int cntLen = (`uartTickDiv > 1) ? $clog2(`uartTickDiv) : 1;
	localparam logic [cntLen-1:0] reload = cntLen'(`uartTickDiv - 1);

	logic [cntLen-1:0] cntReg;  // counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cntReg <= reload;           // first tick div clocks after reset
		else if (cntReg == '0)
			cntReg <= reload;           // wrap
		else
			cntReg <= cntReg - 1'b1;
	end

	assign sTick = (cntReg == '0);  // decoded from a register, one clock wide

endmodule

`default_nettype wire

//--- project.f
+incdir+.
uartPkg.sv
baudGen.sv
uartRec.sv
uartTrans.sv
uartFifo.sv
uartPort.sv
uartTop.sv
uartTb.sv

//--- uartFifo.sv
//////////////////////////////
// byte fifo, register array with read and write pointers
// one instance buffers receive, one buffers transmit
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uartFifo
	import uartPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic       pop,
	input  uartByte_t  wrData,
	output uartByte_t  rdData,
	output fifoFlags_t flags
);

	localparam int aLen  = `uartFifoAddrLen;
	localparam int depth = 1 << aLen;

	uartByte_t       mem [depth];
	logic [aLen-1:0] wrPtr;
	logic [aLen-1:0] rdPtr;
	logic [aLen:0]   cntReg;     // one bit wider, holds 0..depth
	logic            doPush;
	logic            doPop;

	// full drops the push, empty drops the pop
	assign doPush = push && !flags.full;
	assign doPop  = pop && !flags.empty;

	//////////////////////////////
	// pointers and fill count
	//////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			cntReg <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;   // wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   cntReg <= cntReg + 1'b1;
				2'b01:   cntReg <= cntReg - 1'b1;
				default: cntReg <= cntReg;   // none, or both at once
			endcase
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end

	assign rdData      = mem[rdPtr];   // head, first word out
	assign flags.empty = (cntReg == '0);
	assign flags.full  = (cntReg == (aLen + 1)'(depth));

endmodule

`default_nettype wire

//--- uartPkg.sv
//////////////////////////////
// struct types of the serial port
// shared by the rtl and the testbench, import with uartPkg::*
//////////////////////////////
`default_nettype none
`include "uart_settings.svh"

package uartPkg;

	// one data byte as moved on the line and through the fifos
	typedef logic [`uartDataBits-1:0] uartByte_t;

	// processor strobes, one cycle each
	typedef struct packed {
		logic      rd;      // pop one received byte
		logic      wr;      // push wrData toward the line
		logic      stat;    // read status, clear sticky errors
		uartByte_t wrData;
	} uartReq_t;

	// status byte as seen by the processor
	typedef struct packed {
		logic       rxReady;   // receive fifo holds data
		logic       txFull;    // further writes are lost
		logic       txBusy;    // frame on the line or bytes pending
		logic       overrun;   // sticky, byte dropped on full rx fifo
		logic       frameErr;  // sticky, low stop bit seen
		logic [2:0] spare;     // read as zero
	} uartStat_t;

	// read side back to the processor
	typedef struct packed {
		uartByte_t rdData;
		uartStat_t status;
	} uartResp_t;

	// fifo fill state
	typedef struct packed {
		logic empty;
		logic full;
	} fifoFlags_t;

endpackage

`default_nettype wire

//--- uartPort.sv
//////////////////////////////
// processor side of the serial port
// turns rd/wr/stat strobes into fifo pushes and pops,
// starts the transmitter and builds the status byte
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module uartPort
	import uartPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  uartReq_t   req,
	output uartResp_t  resp,
	input  logic       rxDone,
	input  uartByte_t  rxData,
	input  logic       stopBit,
	input  fifoFlags_t rxFlags,
	input  uartByte_t  rxHead,
	output logic       rxPush,
	output logic       rxPop,
	input  fifoFlags_t txFlags,
	output logic       txPush,
	output logic       txPop,
	input  logic       txBusy,
	output logic       txStart
);

	logic overrunReg;    // sticky
	logic frameErrReg;   // sticky
	logic overrunSet;
	logic frameErrSet;

	//////////////////////////////
	// receive side
	//////////////////////////////
	assign rxPush      = rxDone && !rxFlags.full;
	assign overrunSet  = rxDone && rxFlags.full;   // byte is dropped
	assign frameErrSet = rxDone && !stopBit;       // byte is kept anyway
	assign rxPop       = req.rd && !rxFlags.empty;

	//////////////////////////////
	// transmit side
	//////////////////////////////
	assign txPush  = req.wr && !txFlags.full;   // lost when full, txFull warned
	assign txPop   = !txFlags.empty && !txBusy;
	assign txStart = txPop;   // head byte goes out with the pop

	// sticky errors, a new event beats a clear in the same cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrunReg  <= 1'b0;
			frameErrReg <= 1'b0;
		end
		else
		begin
			overrunReg  <= (overrunReg && !req.stat) || overrunSet;
			frameErrReg <= (frameErrReg && !req.stat) || frameErrSet;
		end
	end

	// read data and status, combinational so a strobe sees them at once
	always_comb
	begin
		// empty fifo: last byte from the receiver rather than stale ram
		resp.rdData          = rxFlags.empty ? rxData : rxHead;
		resp.status.rxReady  = !rxFlags.empty;
		resp.status.txFull   = txFlags.full;
		resp.status.txBusy   = txBusy || !txFlags.empty;   // no gap between queued frames
		resp.status.overrun  = overrunReg;
		resp.status.frameErr = frameErrReg;
		resp.status.spare    = 3'b000;
	end

endmodule

`default_nettype wire

//--- uartRec.sv
//////////////////////////////
// oversampling receiver, one start bit, data lsb first, one stop bit
// rxDone pulses one clock per frame with dOut and stopBit valid
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uartRec
	import uartPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      sTick,
	input  logic      rx,
	output logic      rxDone,
	output uartByte_t dOut,
	output logic      stopBit
);

	localparam logic [1:0] idle = 2'b00, start = 2'b01, data = 2'b10, stop = 2'b11;
	localparam int nLen = $clog2(`uartDataBits);

	logic [1:0]      stateReg;
	logic [3:0]      sReg;       // tick counter within a bit
	logic [nLen-1:0] nReg;       // data bit counter
	uartByte_t       bReg;       // shift register, filled from the top
	logic            rxPrev;     // last rx level, for the falling edge
	logic            doneReg;
	logic            stopReg;
	logic            sampleNow;  // middle of a data bit

	assign sampleNow = (stateReg == data) && sTick && (sReg == 4'd15);

	//////////////////////////////
	// control fsm
	//////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			rxPrev   <= 1'b1;   // line idles high
			doneReg  <= 1'b0;
			stopReg  <= 1'b0;
		end
		else
		begin
			rxPrev  <= rx;
			doneReg <= 1'b0;     // single clock pulse
			case (stateReg)
				idle:
					// edge, not level: a low stop bit must not retrigger
					if (rxPrev && !rx)
					begin
						stateReg <= start;
						sReg     <= '0;
					end
				start:
					if (sTick)
					begin
						if (sReg == 4'd7)   // middle of start bit
						begin
							if (rx)
								stateReg <= idle;   // glitch, not a start bit
							else
							begin
								stateReg <= data;
								sReg     <= '0;
								nReg     <= '0;
							end
						end
						else
							sReg <= sReg + 1'b1;
					end
				data:
					if (sTick)
					begin
						if (sReg == 4'd15)
						begin
							sReg <= '0;
							if (nReg == nLen'(`uartDataBits - 1))
								stateReg <= stop;   // last data bit taken
							else
								nReg <= nReg + 1'b1;
						end
						else
							sReg <= sReg + 1'b1;
					end
				stop:
					if (sTick)
					begin
						if (sReg == 4'(`uartStopTicks - 1))   // middle of stop bit
						begin
							stateReg <= idle;
							doneReg  <= 1'b1;
							stopReg  <= rx;   // 0 here means framing error
						end
						else
							sReg <= sReg + 1'b1;
					end
				default:
					stateReg <= idle;
			endcase
		end
	end

	// data shift, lsb arrives first and ends up in bit 0
	always_ff @(posedge clk)
	begin
		if (sampleNow)
			bReg <= {rx, bReg[`uartDataBits-1:1]};
	end

	assign rxDone  = doneReg;
	assign dOut    = bReg;     // stable until the next frame's first data bit
	assign stopBit = stopReg;

endmodule

`default_nettype wire

//--- uartTb.sv
//////////////////////////////
// self-checking testbench of the serial port
// reads uart_cases.txt from the project root, drives rx and the
// processor strobes, decodes tx and checks bytes and status
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uartTb
	import uartPkg::*;
();

	localparam int bitClks = 16 * `uartTickDiv;     // clocks per serial bit
	localparam int depth   = 1 << `uartFifoAddrLen;  // bytes per fifo

	logic      clk;
	logic      reset;
	logic      rx;
	logic      tx;
	uartReq_t  req;
	uartResp_t resp;

	logic [7:0] kindQ [$];   // ascii kind code
	uartByte_t  byteQ [$];   // byte sent, or first byte of a sequence
	logic [7:0] expQ  [$];   // expected byte, status byte for overrun
	int         cycleCount;
	int         cycleLimit;
	int         idx;
	int         runLen;
	int         fd;
	int         nRead;
	string      line;
	logic [7:0] kindRd;
	logic [7:0] byteRd;
	logic [7:0] expRd;

	uartTop UUT (.clk(clk), .reset(reset), .rx(rx), .tx(tx), .req(req), .resp(resp));

	always #20 clk = ~clk;   // 40 ns period

	// watchdog, limit set once the cases are known
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: the run took more than %0d clock cycles", cycleLimit);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic checkByte(input string name, input uartByte_t expected, input uartByte_t actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic checkStat(input string name, input uartStat_t expected, input uartStat_t actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %b, actual %b", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////
	// one clock, inputs move 2 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic waitCycles(input int n);
		repeat (n) nextCycle();
	endtask

	task automatic bitTime(input logic level);
		rx = level;
		waitCycles(bitClks);
	endtask

	// start, data lsb first, stop at the given level
	task automatic sendFrame(input uartByte_t b, input logic stopLevel);
		int i;
		bitTime(1'b0);
		for (i = 0; i < `uartDataBits; i++)
			bitTime(b[i]);
		bitTime(stopLevel);
		if (!stopLevel)
			bitTime(1'b1);   // idle again before a next start edge
	endtask

	// follow tx from the falling edge, sample mid-bit
	task automatic captureFrame(output uartByte_t b, output logic startLvl, output logic stopLvl,
		input logic busyGap, input string name);
		int i;
		while (tx === 1'b1)
		begin
			if (busyGap)
				checkBit({name, " txBusy between frames"}, 1'b1, resp.status.txBusy);
			nextCycle();
		end
		waitCycles(bitClks / 2);
		startLvl = tx;
		for (i = 0; i < `uartDataBits; i++)
		begin
			waitCycles(bitClks);
			b[i] = tx;
		end
		waitCycles(bitClks);
		stopLvl = tx;
	endtask

	// one rd strobe
	task automatic popByte();
		req.rd = 1'b1;
		nextCycle();
		req.rd = 1'b0;
	endtask

	function automatic string caseName(input int n);
		return $sformatf("case %0d kind %c", n + 1, kindQ[n]);
	endfunction

	//////////////////////////////
	// case kinds
	//////////////////////////////
	// frames back to back, read out in arrival order
	task automatic runReceive(input int first, input int n);
		int k;
		for (k = 0; k < n; k++)
			sendFrame(byteQ[first + k], 1'b1);
		while (!resp.status.rxReady)
			nextCycle();
		for (k = 0; k < n; k++)
		begin
			checkByte(caseName(first + k), expQ[first + k], resp.rdData);
			popByte();
		end
		checkBit({caseName(first + n - 1), " rxReady"}, 1'b0, resp.status.rxReady);
	endtask

	// writes in consecutive cycles, frames decoded in write order
	task automatic runTransmit(input int first, input int n);
		int k;
		uartByte_t got;
		logic startLvl;
		logic stopLvl;
		string name;
		for (k = 0; k < n; k++)
		begin
			req.wr     = 1'b1;
			req.wrData = byteQ[first + k];
			nextCycle();
		end
		req.wr     = 1'b0;
		req.wrData = '0;
		for (k = 0; k < n; k++)
		begin
			name = caseName(first + k);
			captureFrame(got, startLvl, stopLvl, k > 0, name);
			checkBit({name, " start bit"}, 1'b0, startLvl);
			checkByte(name, expQ[first + k], got);
			checkBit({name, " stop bit"}, 1'b1, stopLvl);
		end
		waitCycles(bitClks / 2 + 8);   // rest of the stop bit
		checkBit({name, " txBusy after frame"}, 1'b0, resp.status.txBusy);
	endtask

	// low stop bit, byte kept, flag sticky until stat
	task automatic runFrameErr(input int n);
		uartStat_t expStat;
		sendFrame(byteQ[n], 1'b0);
		expStat          = '0;
		expStat.rxReady  = 1'b1;
		expStat.frameErr = 1'b1;
		req.stat = 1'b1;
		checkStat({caseName(n), " status"}, expStat, resp.status);
		nextCycle();
		req.stat = 1'b0;
		expStat.frameErr = 1'b0;
		checkStat({caseName(n), " status after clear"}, expStat, resp.status);
		checkByte(caseName(n), expQ[n], resp.rdData);
		popByte();
		checkBit({caseName(n), " rxReady"}, 1'b0, resp.status.rxReady);
	endtask

	// one frame more than the fifo holds, the last one is dropped
	task automatic runOverrun(input int n);
		int k;
		uartStat_t expStat;
		for (k = 0; k <= depth; k++)
			sendFrame(uartByte_t'(byteQ[n] + k), 1'b1);
		expStat  = uartStat_t'(expQ[n]);
		req.stat = 1'b1;
		checkStat({caseName(n), " status"}, expStat, resp.status);
		nextCycle();
		req.stat = 1'b0;
		expStat.overrun = 1'b0;
		checkStat({caseName(n), " status after clear"}, expStat, resp.status);
		for (k = 0; k < depth; k++)
		begin
			checkByte($sformatf("%s byte %0d", caseName(n), k), uartByte_t'(byteQ[n] + k),
				resp.rdData);
			popByte();
		end
		checkStat({caseName(n), " drained"}, uartStat_t'(8'h00), resp.status);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		clk        = 1'b0;
		reset      = 1'b1;
		rx         = 1'b1;   // line idle
		req        = '0;
		cycleCount = 0;
		idx        = 0;
		fd = $fopen("uart_cases.txt", "r");
		if (fd == 0)
		begin
			$display("the cases file uart_cases.txt could not be opened");
			$display("STATUS: FAIL");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			nRead = $fgets(line, fd);
			if (nRead > 0 && line.getc(0) != "#")   // skip column notes
			begin
				nRead = $sscanf(line, "%c %h %h", kindRd, byteRd, expRd);
				if (nRead == 3)
				begin
					kindQ.push_back(kindRd);
					byteQ.push_back(byteRd);
					expQ.push_back(expRd);
				end
			end
		end
		$fclose(fd);
		cycleLimit = kindQ.size() * 1400 + 200;

		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		checkBit("reset tx level", 1'b1, tx);
		checkStat("reset status", uartStat_t'(8'h00), resp.status);

		while (idx < kindQ.size())
		begin
			runLen = 1;
			// up to three like cases in a row form a burst
			if (kindQ[idx] == "R" || kindQ[idx] == "T")
				while (runLen < 3 && idx + runLen < kindQ.size() &&
					kindQ[idx + runLen] == kindQ[idx])
					runLen++;
			case (kindQ[idx])
				"R": runReceive(idx, runLen);
				"T": runTransmit(idx, runLen);
				"F": runFrameErr(idx);
				"O": runOverrun(idx);
				default:
				begin
					$display("case %0d has an unknown kind code %c", idx + 1, kindQ[idx]);
					$display("STATUS: FAIL");
					$fatal(1);
				end
			endcase
			idx += runLen;
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartTop.sv
//////////////////////////////
// serial port subsystem top
// tick generator, receive and transmit paths, port controller
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module uartTop
	import uartPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      rx,
	output logic      tx,
	input  uartReq_t  req,
	output uartResp_t resp
);

	logic       sTick;
	logic       rxDone;
	logic       stopBit;
	uartByte_t  rxByte;    // receiver output
	uartByte_t  rxHead;
	uartByte_t  txHead;
	fifoFlags_t rxFlags;
	fifoFlags_t txFlags;
	logic       rxPush;
	logic       rxPop;
	logic       txPush;
	logic       txPop;
	logic       txBusy;
	logic       txStart;

	// shared timebase
	baudGen baudGenInst (.clk(clk), .reset(reset), .sTick(sTick));

	//////////////////////////////
	// receive path
	//////////////////////////////
	uartRec uartRecInst (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDone(rxDone), .dOut(rxByte), .stopBit(stopBit)
	);

	uartFifo rxFifo (
		.clk(clk), .reset(reset), .push(rxPush), .pop(rxPop),
		.wrData(rxByte), .rdData(rxHead), .flags(rxFlags)
	);

	//////////////////////////////
	// transmit path
	//////////////////////////////
	uartFifo txFifo (
		.clk(clk), .reset(reset), .push(txPush), .pop(txPop),
		.wrData(req.wrData), .rdData(txHead), .flags(txFlags)
	);

	uartTrans uartTransInst (
		.clk(clk), .reset(reset), .sTick(sTick), .txStart(txStart),
		.txData(txHead), .tx(tx), .busy(txBusy)
	);

	// controller joining both paths
	uartPort uartPortInst (
		.clk(clk), .reset(reset), .req(req), .resp(resp),
		.rxDone(rxDone), .rxData(rxByte), .stopBit(stopBit),
		.rxFlags(rxFlags), .rxHead(rxHead), .rxPush(rxPush), .rxPop(rxPop),
		.txFlags(txFlags), .txPush(txPush), .txPop(txPop),
		.txBusy(txBusy), .txStart(txStart)
	);

endmodule

`default_nettype wire

//--- uartTrans.sv
//////////////////////////////
// serial transmitter, start bit, data lsb first, one stop bit
// txStart with txData starts a frame when idle, busy covers the frame
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uartTrans
	import uartPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      sTick,
	input  logic      txStart,
	input  uartByte_t txData,
	output logic      tx,
	output logic      busy
);

	localparam logic [1:0] idle = 2'b00, start = 2'b01, data = 2'b10, stop = 2'b11;
	localparam int nLen = $clog2(`uartDataBits);

	logic [1:0]      stateReg;
	logic [3:0]      sReg;       // ticks within the current bit
	logic [nLen-1:0] nReg;       // data bits sent
	uartByte_t       bReg;       // outgoing byte, shifts right
	logic            txReg;      // registered line level
	logic            bitEnd;     // last tick of a data bit

	assign bitEnd = (stateReg == data) && sTick && (sReg == 4'd15);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;   // mark level
		end
		else
		begin
			case (stateReg)
				idle:
					if (txStart)
					begin
						stateReg <= start;
						sReg     <= '0;
						txReg    <= 1'b0;   // start bit
					end
				start:
					if (sTick)
					begin
						if (sReg == 4'd15)
						begin
							stateReg <= data;
							sReg     <= '0;
							nReg     <= '0;
							txReg    <= bReg[0];   // first data bit
						end
						else
							sReg <= sReg + 1'b1;
					end
				data:
					if (sTick)
					begin
						if (sReg == 4'd15)
						begin
							sReg <= '0;
							if (nReg == nLen'(`uartDataBits - 1))
							begin
								stateReg <= stop;
								txReg    <= 1'b1;   // stop bit
							end
							else
							begin
								nReg  <= nReg + 1'b1;
								txReg <= bReg[1];   // next bit, before the shift lands
							end
						end
						else
							sReg <= sReg + 1'b1;
					end
				stop:
					if (sTick)
					begin
						if (sReg == 4'(`uartStopTicks - 1))
							stateReg <= idle;   // frame done
						else
							sReg <= sReg + 1'b1;
					end
				default:
					stateReg <= idle;
			endcase
		end
	end

	// byte latch and shift
	always_ff @(posedge clk)
	begin
		if ((stateReg == idle) && txStart)
			bReg <= txData;
		else if (bitEnd)
			bReg <= bReg >> 1;
	end

	assign tx   = txReg;
	assign busy = (stateReg != idle);   // from the clock after txStart

endmodule

`default_nettype wire

//--- uart_cases.txt
# kind byte expected, kind R receive, T transmit, F low stop bit, O overrun
# O: byte starts a sequence of 17 frames, expected is the status byte afterwards
R 55 55
T a5 a5
R 00 00
T 3c 3c
F 7e 7e
R ff ff
T 00 00
R 12 12
R 34 34
R 56 56
T 01 01
F 81 81
T ff ff
O 40 90
T 9a 9a
T bc bc
T de de
R c3 c3
F 00 00
T 80 80
R 5a 5a
T 5a 5a
R a5 a5
F ff ff
T f0 f0
R 0f 0f

//--- uart_settings.svh
//////////////////////////////
// build-time constants of the serial port
// include wherever a width or a count is needed
// the tick divisor sets the baud rate: bit time = 16 * uartTickDiv clocks
//////////////////////////////
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

//////////////////////////////
// frame format
//////////////////////////////
`define uartDataBits    8   // data bits per frame, lsb first
`define uartStopTicks   16  // oversampling ticks in the stop bit (one stop bit)

//////////////////////////////
// buffering
//////////////////////////////
`define uartFifoAddrLen 4   // 2^4 = 16 bytes per fifo

//////////////////////////////
// timebase
//////////////////////////////
// clocks per 16x oversampling tick
// 4 keeps simulation short, one bit = 64 clocks
`define uartTickDiv     4

`endif
